/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_zynq_bridge
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# the run passes only when the log holds the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG); grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* logic/addr_map.sv */
`timescale 1ns/1ps

module addr_map
   (input  logic [zynq_bridge_pkg::HOST_ADDR_W-1:0]  host_awaddr_i
   ,input  logic [zynq_bridge_pkg::HOST_ADDR_W-1:0]  host_araddr_i
   ,output logic [zynq_bridge_pkg::BP_ADDR_W-1:0]    bp_awaddr_o
   ,output logic [zynq_bridge_pkg::BP_ADDR_W-1:0]    bp_araddr_o

   ,input  logic [zynq_bridge_pkg::MEM_ADDR_W-1:0]   mem_awaddr_i
   ,input  logic [zynq_bridge_pkg::MEM_ADDR_W-1:0]   mem_araddr_i
   ,input  logic [zynq_bridge_pkg::AXIL_DATA_W-1:0]  dram_base_i
   ,output logic [zynq_bridge_pkg::DRAM_ADDR_W-1:0]  dram_awaddr_o
   ,output logic [zynq_bridge_pkg::DRAM_ADDR_W-1:0]  dram_araddr_o
   );

   import zynq_bridge_pkg::*;

   // S01 offsets 0x0000_0000 and up land on cached dram at 0x8000_0000
   // and offsets above 0x2000_0000 fold back onto the tile window at zero
   function automatic logic [BP_ADDR_W-1:0] host_xlate
      (input logic [HOST_ADDR_W-1:0] addr);
      logic [BP_ADDR_W-1:0] offset;
      offset = BP_DRAM_BASE;
      if (BP_ADDR_W'(addr) > TILE_WINDOW_BASE)
         offset = TILE_WINDOW_BASE;
      return BP_ADDR_W'(addr) ^ offset;
   endfunction

   // memory-side addresses start at the core's dram base
   // so that base is swapped for the buffer the PS allocated
   function automatic logic [DRAM_ADDR_W-1:0] dram_remap
      (input logic [MEM_ADDR_W-1:0]  addr
      ,input logic [AXIL_DATA_W-1:0] base);
      logic [MEM_ADDR_W-1:0] sum;
      sum = addr - MEM_ADDR_W'(BP_DRAM_BASE) + MEM_ADDR_W'(base);
      return sum[DRAM_ADDR_W-1:0];
   endfunction

   // all four paths are purely combinational
   always_comb
   begin
      bp_awaddr_o   = host_xlate(host_awaddr_i);
      bp_araddr_o   = host_xlate(host_araddr_i);
      dram_awaddr_o = dram_remap(mem_awaddr_i, dram_base_i);
      dram_araddr_o = dram_remap(mem_araddr_i, dram_base_i);
   end

endmodule

/* logic/axil_ctrl_slave.sv */
`timescale 1ns/1ps

module axil_ctrl_slave
   (input  logic                                          aclk_i
   ,input  logic                                          arst_n_i

   ,input  zynq_bridge_pkg::axil_aw_s                     ctrl_aw_i
   ,input  logic                                          ctrl_awvalid_i
   ,output logic                                          ctrl_awready_o
   ,input  zynq_bridge_pkg::axil_w_s                      ctrl_w_i
   ,input  logic                                          ctrl_wvalid_i
   ,output logic                                          ctrl_wready_o
   ,output logic [zynq_bridge_pkg::AXI_RESP_W-1:0]        ctrl_bresp_o
   ,output logic                                          ctrl_bvalid_o
   ,input  logic                                          ctrl_bready_i
   ,input  zynq_bridge_pkg::axil_ar_s                     ctrl_ar_i
   ,input  logic                                          ctrl_arvalid_i
   ,output logic                                          ctrl_arready_o
   ,output zynq_bridge_pkg::axil_r_s                      ctrl_r_o
   ,output logic                                          ctrl_rvalid_o
   ,input  logic                                          ctrl_rready_i

   ,input  logic [zynq_bridge_pkg::AXIL_DATA_W-1:0]       status_i
   ,output zynq_bridge_pkg::csr_bank_t                    csr_o

   ,output logic [zynq_bridge_pkg::AXIL_DATA_W-1:0]       tx_data_o
   ,output logic                                          tx_push_o
   ,input  logic                                          tx_ready_i

   ,input  logic [zynq_bridge_pkg::AXIL_DATA_W-1:0]       rx_data_i
   ,input  logic                                          rx_v_i
   ,output logic                                          rx_pop_o
   );

   import zynq_bridge_pkg::*;

   logic                    wr_ready_q;
   logic                    bvalid_q;
   logic [AXI_RESP_W-1:0]   bresp_q;
   logic                    arready_q;
   logic                    rvalid_q;
   axil_r_s                 r_q;
   csr_bank_t               csr_q;
   logic                    wr_hs;
   logic                    rd_hs;
   logic [2:0]              aw_word;
   logic [2:0]              ar_word;
   logic                    aw_aligned;
   logic                    ar_aligned;
   logic [AXIL_DATA_W-1:0]  rd_data;

   // a handshake completes in the single cycle the slave holds ready high
   assign wr_hs = wr_ready_q & ctrl_awvalid_i & ctrl_wvalid_i;
   assign rd_hs = arready_q & ctrl_arvalid_i;

   // the word index comes from the split view of the address
   assign aw_word = ctrl_aw_i.addr.fields.word;
   assign ar_word = ctrl_ar_i.addr.fields.word;

   // the byte address has to sit on a full data word
   assign aw_aligned = (ctrl_aw_i.addr.raw & CTRL_ADDR_W'(AXIL_STRB_W - 1)) == '0;
   assign ar_aligned = (ctrl_ar_i.addr.raw & CTRL_ADDR_W'(AXIL_STRB_W - 1)) == '0;

   // AW and W are taken together, and only once the last B has been accepted
   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ready_q <= 1'b0;
         bvalid_q   <= 1'b0;
      end
      else
      begin
         wr_ready_q <= ctrl_awvalid_i & ctrl_wvalid_i & ~bvalid_q & ~wr_ready_q;
         if (wr_hs)
            bvalid_q <= 1'b1;
         else if (ctrl_bready_i)
            bvalid_q <= 1'b0;
      end
   end

   // reads follow the same scheme on their own path
   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         arready_q <= 1'b0;
         rvalid_q  <= 1'b0;
      end
      else
      begin
         arready_q <= ctrl_arvalid_i & ~rvalid_q & ~arready_q;
         if (rd_hs)
            rvalid_q <= 1'b1;
         else if (ctrl_rready_i)
            rvalid_q <= 1'b0;
      end
   end

   // each byte lane of a control register only changes where its strobe is set
   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         csr_q <= '0;
      else if (wr_hs && aw_aligned)
      begin
         for (int r = 0; r < NUM_CSR; r++)
         begin
            for (int b = 0; b < AXIL_STRB_W; b++)
            begin
               if (aw_word == REG_CSR0 + 3'(r) && ctrl_w_i.strb[b])
                  csr_q[r][8*b +: 8] <= ctrl_w_i.data[8*b +: 8];
            end
         end
      end
   end

   // read data for the word addressed on AR
   always_comb
   begin
      rd_data = '0;
      case (ar_word)
         REG_CSR0:    rd_data = csr_q[0];
         REG_CSR1:    rd_data = csr_q[1];
         REG_CSR2:    rd_data = csr_q[2];
         REG_STATUS:  rd_data = status_i;
         REG_TX_PUSH: rd_data = '0;
         // an empty FIFO reads as zero and is left alone
         REG_RX_POP:  rd_data = rx_v_i ? rx_data_i : '0;
         REG_FLAGS:   rd_data = AXIL_DATA_W'({~tx_ready_i, rx_v_i});
         default:     rd_data = '0;
      endcase
      if (!ar_aligned)
         rd_data = '0;
   end

   // response payloads are captured at the handshake and held with valid
   always_ff @(posedge aclk_i)
   begin
      if (wr_hs)
         bresp_q <= aw_aligned ? RESP_OKAY : RESP_SLVERR;
      if (rd_hs)
      begin
         r_q.data <= rd_data;
         r_q.resp <= ar_aligned ? RESP_OKAY : RESP_SLVERR;
      end
   end

   // FIFO strobes fire on the handshake cycle of an aligned access
   assign tx_data_o = ctrl_w_i.data;
   assign tx_push_o = wr_hs & aw_aligned & (aw_word == REG_TX_PUSH) & tx_ready_i;
   assign rx_pop_o  = rd_hs & ar_aligned & (ar_word == REG_RX_POP) & rx_v_i;

   assign ctrl_awready_o = wr_ready_q;
   assign ctrl_wready_o  = wr_ready_q;
   assign ctrl_bvalid_o  = bvalid_q;
   assign ctrl_bresp_o   = bresp_q;
   assign ctrl_arready_o = arready_q;
   assign ctrl_rvalid_o  = rvalid_q;
   assign ctrl_r_o       = r_q;
   assign csr_o          = csr_q;

   // the host keeps W valid while the slave answers its AW
   awready_needs_w_a: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      $rose(ctrl_awready_o) |-> ctrl_wvalid_i);

   // a write response stays up until the host takes it
   bvalid_hold_a: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      ctrl_bvalid_o && !ctrl_bready_i |=> ctrl_bvalid_o);

endmodule

/* logic/shell_fifo.sv */
`timescale 1ns/1ps

module shell_fifo
   #(parameter int depth_p = zynq_bridge_pkg::FIFO_DEPTH
   )
   (input  logic                                     aclk_i
   ,input  logic                                     arst_n_i

   ,input  logic [zynq_bridge_pkg::AXIL_DATA_W-1:0]  data_i
   ,input  logic                                     v_i
   ,output logic                                     ready_o

   ,output logic [zynq_bridge_pkg::AXIL_DATA_W-1:0]  data_o
   ,output logic                                     v_o
   ,input  logic                                     yumi_i
   );

   import zynq_bridge_pkg::*;

   localparam int ptr_w_lp   = (depth_p > 1) ? $clog2(depth_p) : 1;
   localparam int count_w_lp = $clog2(depth_p + 1);

   logic [AXIL_DATA_W-1:0] mem_q [depth_p];
   logic [ptr_w_lp-1:0]    wr_ptr_q;
   logic [ptr_w_lp-1:0]    rd_ptr_q;
   logic [count_w_lp-1:0]  count_q;
   logic                   push;
   logic                   pop;

   assign push = v_i & ready_o;
   assign pop  = yumi_i & v_o;

   // storage is written on a push and read straight from the read pointer
   always_ff @(posedge aclk_i)
   begin
      if (push)
         mem_q[wr_ptr_q] <= data_i;
   end

   always_ff @(posedge aclk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         // pointers wrap at the last entry so any depth works
         if (push)
            wr_ptr_q <= (wr_ptr_q == ptr_w_lp'(depth_p - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (pop)
            rd_ptr_q <= (rd_ptr_q == ptr_w_lp'(depth_p - 1)) ? '0 : rd_ptr_q + 1'b1;
         if (push && !pop)
            count_q <= count_q + 1'b1;
         else if (pop && !push)
            count_q <= count_q - 1'b1;
      end
   end

   assign ready_o = count_q != count_w_lp'(depth_p);
   assign v_o     = count_q != '0;
   assign data_o  = mem_q[rd_ptr_q];

   // the consumer may only take what the FIFO is offering
   yumi_needs_v_a: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      yumi_i |-> v_o);

   count_bound_a: assert property (@(posedge aclk_i) disable iff (!arst_n_i)
      count_q <= count_w_lp'(depth_p));

endmodule

/* logic/zynq_bridge_pkg.sv */
package zynq_bridge_pkg;

   // control port (S00) widths
   localparam int AXIL_DATA_W = 32;
   localparam int AXIL_STRB_W = AXIL_DATA_W / 8;
   localparam int CTRL_ADDR_W = 5;
   localparam int AXI_PROT_W  = 3;
   localparam int AXI_RESP_W  = 2;

   localparam logic [AXI_RESP_W-1:0] RESP_OKAY   = 2'b00;
   localparam logic [AXI_RESP_W-1:0] RESP_SLVERR = 2'b10;

   // the PS drops the top two bits of the S01 address
   localparam int HOST_ADDR_W = 30;
   localparam int BP_ADDR_W   = 32;
   localparam int MEM_ADDR_W  = 33;
   localparam int DRAM_ADDR_W = 32;

   // start of cached dram in the core's address space
   localparam logic [31:0] BP_DRAM_BASE     = 32'h8000_0000;
   // S01 addresses above this point reach the tile window
   localparam logic [31:0] TILE_WINDOW_BASE = 32'h2000_0000;

   localparam int NUM_CSR    = 3;
   localparam int FIFO_DEPTH = 4;

   // word indices of the control register map
   localparam logic [2:0] REG_CSR0    = 3'd0;
   localparam logic [2:0] REG_CSR1    = 3'd1;
   localparam logic [2:0] REG_CSR2    = 3'd2;
   localparam logic [2:0] REG_STATUS  = 3'd3;
   localparam logic [2:0] REG_TX_PUSH = 3'd4;
   localparam logic [2:0] REG_RX_POP  = 3'd5;
   localparam logic [2:0] REG_FLAGS   = 3'd6;

   typedef struct packed {
      logic [2:0] word;
      logic [1:0] offset;
   } ctrl_addr_fields_s;

   // the control address seen as a byte address or as word and byte offset
   typedef union packed {
      logic [CTRL_ADDR_W-1:0] raw;
      ctrl_addr_fields_s      fields;
   } ctrl_addr_u;

   typedef struct packed {
      ctrl_addr_u              addr;
      logic [AXI_PROT_W-1:0]   prot;
   } axil_aw_s;

   typedef axil_aw_s axil_ar_s;

   typedef struct packed {
      logic [AXIL_DATA_W-1:0]  data;
      logic [AXIL_STRB_W-1:0]  strb;
   } axil_w_s;

   typedef struct packed {
      logic [AXIL_DATA_W-1:0]  data;
      logic [AXI_RESP_W-1:0]   resp;
   } axil_r_s;

   typedef logic [NUM_CSR-1:0][AXIL_DATA_W-1:0] csr_bank_t;

endpackage

/* logic/zynq_bridge_top.sv */
`timescale 1ns/1ps

module zynq_bridge_top
   (input  logic                                          aclk_i
   ,input  logic                                          arst_n_i

   // S00 control port
   ,input  zynq_bridge_pkg::axil_aw_s                     ctrl_aw_i
   ,input  logic                                          ctrl_awvalid_i
   ,output logic                                          ctrl_awready_o
   ,input  zynq_bridge_pkg::axil_w_s                      ctrl_w_i
   ,input  logic                                          ctrl_wvalid_i
   ,output logic                                          ctrl_wready_o
   ,output logic [zynq_bridge_pkg::AXI_RESP_W-1:0]        ctrl_bresp_o
   ,output logic                                          ctrl_bvalid_o
   ,input  logic                                          ctrl_bready_i
   ,input  zynq_bridge_pkg::axil_ar_s                     ctrl_ar_i
   ,input  logic                                          ctrl_arvalid_i
   ,output logic                                          ctrl_arready_o
   ,output zynq_bridge_pkg::axil_r_s                      ctrl_r_o
   ,output logic                                          ctrl_rvalid_o
   ,input  logic                                          ctrl_rready_i

   ,input  logic [zynq_bridge_pkg::AXIL_DATA_W-1:0]       status_i
   ,output zynq_bridge_pkg::csr_bank_t                    csr_o

   // user side of the PL-to-PS FIFO
   ,input  logic [zynq_bridge_pkg::AXIL_DATA_W-1:0]       pl_to_ps_data_i
   ,input  logic                                          pl_to_ps_v_i
   ,output logic                                          pl_to_ps_ready_o

   // user side of the PS-to-PL FIFO
   ,output logic [zynq_bridge_pkg::AXIL_DATA_W-1:0]       ps_to_pl_data_o
   ,output logic                                          ps_to_pl_v_o
   ,input  logic                                          ps_to_pl_yumi_i

   // S01 host addresses and their translation into the core
   ,input  logic [zynq_bridge_pkg::HOST_ADDR_W-1:0]       host_awaddr_i
   ,input  logic [zynq_bridge_pkg::HOST_ADDR_W-1:0]       host_araddr_i
   ,output logic [zynq_bridge_pkg::BP_ADDR_W-1:0]         bp_awaddr_o
   ,output logic [zynq_bridge_pkg::BP_ADDR_W-1:0]         bp_araddr_o

   // memory-side addresses and their M00 dram remap
   ,input  logic [zynq_bridge_pkg::MEM_ADDR_W-1:0]        mem_awaddr_i
   ,input  logic [zynq_bridge_pkg::MEM_ADDR_W-1:0]        mem_araddr_i
   ,output logic [zynq_bridge_pkg::DRAM_ADDR_W-1:0]       dram_awaddr_o
   ,output logic [zynq_bridge_pkg::DRAM_ADDR_W-1:0]       dram_araddr_o
   );

   import zynq_bridge_pkg::*;

   csr_bank_t               csr_bank;
   logic [AXIL_DATA_W-1:0]  tx_data;
   logic                    tx_push;
   logic                    tx_ready;
   logic [AXIL_DATA_W-1:0]  rx_data;
   logic                    rx_v;
   logic                    rx_pop;

   assign csr_o = csr_bank;

   axil_ctrl_slave ctrl
      (.aclk_i         (aclk_i)
      ,.arst_n_i       (arst_n_i)
      ,.ctrl_aw_i      (ctrl_aw_i)
      ,.ctrl_awvalid_i (ctrl_awvalid_i)
      ,.ctrl_awready_o (ctrl_awready_o)
      ,.ctrl_w_i       (ctrl_w_i)
      ,.ctrl_wvalid_i  (ctrl_wvalid_i)
      ,.ctrl_wready_o  (ctrl_wready_o)
      ,.ctrl_bresp_o   (ctrl_bresp_o)
      ,.ctrl_bvalid_o  (ctrl_bvalid_o)
      ,.ctrl_bready_i  (ctrl_bready_i)
      ,.ctrl_ar_i      (ctrl_ar_i)
      ,.ctrl_arvalid_i (ctrl_arvalid_i)
      ,.ctrl_arready_o (ctrl_arready_o)
      ,.ctrl_r_o       (ctrl_r_o)
      ,.ctrl_rvalid_o  (ctrl_rvalid_o)
      ,.ctrl_rready_i  (ctrl_rready_i)
      ,.status_i       (status_i)
      ,.csr_o          (csr_bank)
      ,.tx_data_o      (tx_data)
      ,.tx_push_o      (tx_push)
      ,.tx_ready_i     (tx_ready)
      ,.rx_data_i      (rx_data)
      ,.rx_v_i         (rx_v)
      ,.rx_pop_o       (rx_pop)
      );

   // words the PS pushes through register 4 come out on the PL side
   shell_fifo ps_to_pl_fifo
      (.aclk_i   (aclk_i)
      ,.arst_n_i (arst_n_i)
      ,.data_i   (tx_data)
      ,.v_i      (tx_push)
      ,.ready_o  (tx_ready)
      ,.data_o   (ps_to_pl_data_o)
      ,.v_o      (ps_to_pl_v_o)
      ,.yumi_i   (ps_to_pl_yumi_i)
      );

   // PL words wait here until the PS pops them through register 5
   shell_fifo pl_to_ps_fifo
      (.aclk_i   (aclk_i)
      ,.arst_n_i (arst_n_i)
      ,.data_i   (pl_to_ps_data_i)
      ,.v_i      (pl_to_ps_v_i)
      ,.ready_o  (pl_to_ps_ready_o)
      ,.data_o   (rx_data)
      ,.v_o      (rx_v)
      ,.yumi_i   (rx_pop)
      );

   // control register 2 holds the physical base of the PS dram buffer
   addr_map xlate
      (.host_awaddr_i (host_awaddr_i)
      ,.host_araddr_i (host_araddr_i)
      ,.bp_awaddr_o   (bp_awaddr_o)
      ,.bp_araddr_o   (bp_araddr_o)
      ,.mem_awaddr_i  (mem_awaddr_i)
      ,.mem_araddr_i  (mem_araddr_i)
      ,.dram_base_i   (csr_bank[REG_CSR2])
      ,.dram_awaddr_o (dram_awaddr_o)
      ,.dram_araddr_o (dram_araddr_o)
      );

endmodule

/* project.f */
+incdir+tb
logic/zynq_bridge_pkg.sv
logic/shell_fifo.sv
logic/addr_map.sv
logic/axil_ctrl_slave.sv
logic/zynq_bridge_top.sv
tb/tb_zynq_bridge.sv

/* tb/tb_zynq_bridge_tasks.svh */
// one compare task per kind of DUT result

task automatic check_r(input axil_r_s got, input axil_r_s exp);
   if (got !== exp)
      stop_on_mismatch($sformatf("R data %h resp %b, expected data %h resp %b",
         got.data, got.resp, exp.data, exp.resp));
endtask

task automatic check_bresp(input logic [AXI_RESP_W-1:0] got, input logic [AXI_RESP_W-1:0] exp);
   if (got !== exp)
      stop_on_mismatch($sformatf("B resp %b, expected %b", got, exp));
endtask

task automatic check_bp_addr(input logic [BP_ADDR_W-1:0] got, input logic [BP_ADDR_W-1:0] exp);
   if (got !== exp)
      stop_on_mismatch($sformatf("core address %h, expected %h", got, exp));
endtask

task automatic check_dram_addr(input logic [DRAM_ADDR_W-1:0] got,
                               input logic [DRAM_ADDR_W-1:0] exp);
   if (got !== exp)
      stop_on_mismatch($sformatf("dram address %h, expected %h", got, exp));
endtask

task automatic check_csr(input csr_bank_t got, input csr_bank_t exp);
   if (got !== exp)
      stop_on_mismatch($sformatf("control bank %h, expected %h", got, exp));
endtask

task automatic check_word(input logic [AXIL_DATA_W-1:0] got, input logic [AXIL_DATA_W-1:0] exp);
   if (got !== exp)
      stop_on_mismatch($sformatf("PS-to-PL word %h, expected %h", got, exp));
endtask

// control address built from word index and byte offset with a random prot field
function automatic axil_aw_s ctrl_addr(input logic [2:0] word, input logic [1:0] offset);
   axil_aw_s a;
   a.addr.raw = {word, offset};
   a.prot     = AXI_PROT_W'($urandom);
   return a;
endfunction

// AW and W of an AXI-lite write are offered together and held until accepted
// the model is updated on the handshake edge and bready is held back a few cycles
task automatic axil_write(input axil_aw_s aw, input axil_w_s w);
   logic [AXI_RESP_W-1:0] exp_resp;
   ctrl_aw      <= aw;
   ctrl_w       <= w;
   ctrl_awvalid <= 1'b1;
   ctrl_wvalid  <= 1'b1;
   do
      @(posedge aclk);
   while (!(ctrl_awready && ctrl_wready));
   exp_resp = model_write(aw, w);
   ctrl_awvalid <= 1'b0;
   ctrl_wvalid  <= 1'b0;
   ctrl_bready  <= 1'b0;
   repeat ($urandom % 4)
      @(posedge aclk);
   ctrl_bready  <= 1'b1;
   do
      @(posedge aclk);
   while (!(ctrl_bvalid && ctrl_bready));
   check_bresp(ctrl_bresp, exp_resp);
endtask

// the expected beat of an AXI-lite read is taken from the model at the AR handshake
// and rready is held back a few cycles before the beat is taken
task automatic axil_read(input axil_ar_s ar);
   axil_r_s exp_r;
   ctrl_ar      <= ar;
   ctrl_arvalid <= 1'b1;
   do
      @(posedge aclk);
   while (!ctrl_arready);
   exp_r = model_read(ar);
   ctrl_arvalid <= 1'b0;
   ctrl_rready  <= 1'b0;
   repeat ($urandom % 4)
      @(posedge aclk);
   ctrl_rready  <= 1'b1;
   do
      @(posedge aclk);
   while (!(ctrl_rvalid && ctrl_rready));
   check_r(ctrl_r, exp_r);
endtask

// a PL-side push is made only while the FIFO has room
task automatic push_pl_word(input logic [AXIL_DATA_W-1:0] data);
   @(posedge aclk);
   if (pl_to_ps_ready !== (rx_q.size() < FIFO_DEPTH))
      stop_on_mismatch("pl_to_ps_ready_o disagrees with the model occupancy");
   if (pl_to_ps_ready)
   begin
      pl_to_ps_data <= data;
      pl_to_ps_v    <= 1'b1;
      @(posedge aclk);
      rx_q.push_back(data);
      pl_to_ps_v    <= 1'b0;
   end
endtask

// the address paths are combinational, so they are checked mid-cycle
task automatic check_host_pair(input logic [HOST_ADDR_W-1:0] aw, input logic [HOST_ADDR_W-1:0] ar);
   host_awaddr <= aw;
   host_araddr <= ar;
   @(negedge aclk);
   check_bp_addr(bp_awaddr, expect_bp(aw));
   check_bp_addr(bp_araddr, expect_bp(ar));
   @(posedge aclk);
endtask

task automatic check_dram_pair(input logic [MEM_ADDR_W-1:0] aw, input logic [MEM_ADDR_W-1:0] ar);
   mem_awaddr <= aw;
   mem_araddr <= ar;
   @(negedge aclk);
   check_dram_addr(dram_awaddr, expect_dram(aw));
   check_dram_addr(dram_araddr, expect_dram(ar));
   @(posedge aclk);
endtask

/* tb/tb_zynq_bridge.sv */
`timescale 1ns/1ps

module tb_zynq_bridge;

   import zynq_bridge_pkg::*;

   localparam int CLK_PERIOD = 100;
   localparam int CSR_ITERS  = 60;
   localparam int MIS_ITERS  = 10;
   localparam int STAT_ITERS = 8;
   localparam int TX_ITERS   = 40;
   localparam int RX_ROUNDS  = 12;
   localparam int HOST_ITERS = 50;
   localparam int DRAM_BASES = 4;
   localparam int DRAM_ITERS = 20;
   // every access, push or address check counts as one operation of at most 20 cycles
   localparam int OP_COUNT = 16 + 4 + CSR_ITERS * 3 + MIS_ITERS * 3 + STAT_ITERS * 3
                           + TX_ITERS * 2 + 20 + RX_ROUNDS * 14 + HOST_ITERS + 2
                           + DRAM_BASES * (DRAM_ITERS + 2);

   logic                    aclk;
   logic                    arst_n;
   axil_aw_s                ctrl_aw;
   logic                    ctrl_awvalid;
   logic                    ctrl_awready;
   axil_w_s                 ctrl_w;
   logic                    ctrl_wvalid;
   logic                    ctrl_wready;
   logic [AXI_RESP_W-1:0]   ctrl_bresp;
   logic                    ctrl_bvalid;
   logic                    ctrl_bready;
   axil_ar_s                ctrl_ar;
   logic                    ctrl_arvalid;
   logic                    ctrl_arready;
   axil_r_s                 ctrl_r;
   logic                    ctrl_rvalid;
   logic                    ctrl_rready;
   logic [AXIL_DATA_W-1:0]  status;
   csr_bank_t               csr;
   logic [AXIL_DATA_W-1:0]  pl_to_ps_data;
   logic                    pl_to_ps_v;
   logic                    pl_to_ps_ready;
   logic [AXIL_DATA_W-1:0]  ps_to_pl_data;
   logic                    ps_to_pl_v;
   logic                    ps_to_pl_yumi;
   logic [HOST_ADDR_W-1:0]  host_awaddr;
   logic [HOST_ADDR_W-1:0]  host_araddr;
   logic [BP_ADDR_W-1:0]    bp_awaddr;
   logic [BP_ADDR_W-1:0]    bp_araddr;
   logic [MEM_ADDR_W-1:0]   mem_awaddr;
   logic [MEM_ADDR_W-1:0]   mem_araddr;
   logic [DRAM_ADDR_W-1:0]  dram_awaddr;
   logic [DRAM_ADDR_W-1:0]  dram_araddr;

   // reference model state
   csr_bank_t               csr_m;
   logic [AXIL_DATA_W-1:0]  tx_q [$];
   logic [AXIL_DATA_W-1:0]  rx_q [$];
   time                     tx_pop_time;
   logic                    pop_enable;

   `include "tb_zynq_bridge_tasks.svh"

   zynq_bridge_top i_dut
      (.aclk_i           (aclk)
      ,.arst_n_i         (arst_n)
      ,.ctrl_aw_i        (ctrl_aw)
      ,.ctrl_awvalid_i   (ctrl_awvalid)
      ,.ctrl_awready_o   (ctrl_awready)
      ,.ctrl_w_i         (ctrl_w)
      ,.ctrl_wvalid_i    (ctrl_wvalid)
      ,.ctrl_wready_o    (ctrl_wready)
      ,.ctrl_bresp_o     (ctrl_bresp)
      ,.ctrl_bvalid_o    (ctrl_bvalid)
      ,.ctrl_bready_i    (ctrl_bready)
      ,.ctrl_ar_i        (ctrl_ar)
      ,.ctrl_arvalid_i   (ctrl_arvalid)
      ,.ctrl_arready_o   (ctrl_arready)
      ,.ctrl_r_o         (ctrl_r)
      ,.ctrl_rvalid_o    (ctrl_rvalid)
      ,.ctrl_rready_i    (ctrl_rready)
      ,.status_i         (status)
      ,.csr_o            (csr)
      ,.pl_to_ps_data_i  (pl_to_ps_data)
      ,.pl_to_ps_v_i     (pl_to_ps_v)
      ,.pl_to_ps_ready_o (pl_to_ps_ready)
      ,.ps_to_pl_data_o  (ps_to_pl_data)
      ,.ps_to_pl_v_o     (ps_to_pl_v)
      ,.ps_to_pl_yumi_i  (ps_to_pl_yumi)
      ,.host_awaddr_i    (host_awaddr)
      ,.host_araddr_i    (host_araddr)
      ,.bp_awaddr_o      (bp_awaddr)
      ,.bp_araddr_o      (bp_araddr)
      ,.mem_awaddr_i     (mem_awaddr)
      ,.mem_araddr_i     (mem_araddr)
      ,.dram_awaddr_o    (dram_awaddr)
      ,.dram_araddr_o    (dram_araddr)
      );

   initial
   begin : clock_gen
      aclk = 1'b0;
      forever
         #(CLK_PERIOD / 2) aclk = ~aclk;
   end

   initial
   begin : watchdog
      #(OP_COUNT * 20 * CLK_PERIOD);
      $display("timeout: test did not finish");
      $display("RESULT: FAIL");
      $fatal(1);
   end

   task automatic stop_on_mismatch(input string msg);
      $display("FAILED at %0t ns: %s", $time, msg);
      $display("RESULT: FAIL");
      $fatal(1);
   endtask

   // the PL-side consumer of the PS-to-PL FIFO checks every word it takes
   // yumi is only raised when v is high and no pop happened on this edge,
   // so the FIFO is sure to still hold a word at the next edge
   initial
   begin : ps_to_pl_consumer
      logic popped;
      ps_to_pl_yumi <= 1'b0;
      tx_pop_time = '1;
      forever
      begin
         @(posedge aclk);
         popped = ps_to_pl_yumi && ps_to_pl_v;
         if (popped)
         begin
            tx_pop_time = $time;
            if (tx_q.size() == 0)
               stop_on_mismatch("PS-to-PL FIFO offered a word the model does not hold");
            else
               check_word(ps_to_pl_data, tx_q.pop_front());
         end
         ps_to_pl_yumi <= pop_enable && ps_to_pl_v && !popped && ($urandom % 2 == 1);
      end
   end

   // above the tile window base the S01 window bit is stripped
   // and everything else lands in cached dram
   function automatic logic [BP_ADDR_W-1:0] expect_bp(input logic [HOST_ADDR_W-1:0] a);
      logic [BP_ADDR_W-1:0] wide;
      wide = BP_ADDR_W'(a);
      if (wide > TILE_WINDOW_BASE)
         return wide ^ TILE_WINDOW_BASE;
      return wide ^ BP_DRAM_BASE;
   endfunction

   // only the low 32 bits survive, so the sum can be formed in 32 bits
   function automatic logic [DRAM_ADDR_W-1:0] expect_dram(input logic [MEM_ADDR_W-1:0] a);
      return a[DRAM_ADDR_W-1:0] - BP_DRAM_BASE + csr_m[2];
   endfunction

   // occupancy as the DUT saw it at this edge, before a pop on the same edge
   function automatic logic tx_full_now();
      int held;
      held = tx_q.size();
      if (tx_pop_time == $time)
         held++;
      return held >= FIFO_DEPTH;
   endfunction

   // applied at the write handshake edge
   function automatic logic [AXI_RESP_W-1:0] model_write(input axil_aw_s aw, input axil_w_s w);
      logic [2:0] word;
      word = aw.addr.raw[4:2];
      if (aw.addr.raw[1:0] != 2'b00)
         return RESP_SLVERR;
      if (word <= REG_CSR2)
      begin
         for (int b = 0; b < AXIL_STRB_W; b++)
         begin
            if (w.strb[b])
               csr_m[word[1:0]][8*b +: 8] = w.data[8*b +: 8];
         end
      end
      else if (word == REG_TX_PUSH && !tx_full_now())
         tx_q.push_back(w.data);
      return RESP_OKAY;
   endfunction

   // applied at the read handshake edge
   // a read of word 5 pops the model queue
   function automatic axil_r_s model_read(input axil_ar_s ar);
      axil_r_s r;
      r.data = '0;
      r.resp = RESP_OKAY;
      if (ar.addr.raw[1:0] != 2'b00)
      begin
         r.resp = RESP_SLVERR;
         return r;
      end
      case (ar.addr.raw[4:2])
         REG_CSR0, REG_CSR1, REG_CSR2:
            r.data = csr_m[ar.addr.raw[3:2]];
         REG_STATUS:
            r.data = status;
         REG_RX_POP:
            if (rx_q.size() > 0)
               r.data = rx_q.pop_front();
         REG_FLAGS:
            r.data = {30'd0, tx_full_now(), rx_q.size() > 0};
         default:
            r.data = '0;
      endcase
      return r;
   endfunction

   task automatic test_csr();
      logic [2:0] word;
      logic [1:0] off;
      axil_w_s    w;
      for (int i = 0; i < CSR_ITERS; i++)
      begin
         word   = 3'($urandom % 3);
         w.data = $urandom;
         w.strb = AXIL_STRB_W'($urandom);
         axil_write(ctrl_addr(word, 2'd0), w);
         check_csr(csr, csr_m);
         axil_read(ctrl_addr(word, 2'd0));
      end
      // misaligned accesses must leave the bank alone
      for (int i = 0; i < MIS_ITERS; i++)
      begin
         word   = 3'($urandom % 3);
         off    = 2'($urandom % 3 + 1);
         w.data = $urandom;
         w.strb = '1;
         axil_write(ctrl_addr(word, off), w);
         check_csr(csr, csr_m);
         axil_read(ctrl_addr(word, off));
      end
   endtask

   task automatic test_status();
      axil_w_s w;
      for (int i = 0; i < STAT_ITERS; i++)
      begin
         status <= $urandom;
         axil_read(ctrl_addr(REG_STATUS, 2'd0));
         w.data = $urandom;
         w.strb = '1;
         axil_write(ctrl_addr(REG_STATUS, 2'd0), w);
         check_csr(csr, csr_m);
         axil_read(ctrl_addr(3'd7, 2'd0));
      end
   endtask

   task automatic test_ps_to_pl();
      axil_w_s w;
      for (int i = 0; i < TX_ITERS; i++)
      begin
         // the consumer pauses for stretches so that the FIFO fills and drops
         pop_enable <= (i % 16) >= 8;
         w.data = $urandom;
         w.strb = '1;
         axil_write(ctrl_addr(REG_TX_PUSH, 2'd0), w);
         axil_read(ctrl_addr(REG_FLAGS, 2'd0));
      end
      pop_enable <= 1'b1;
      while (tx_q.size() != 0)
         @(posedge aclk);
      pop_enable <= 1'b0;
      @(posedge aclk);
      if (ps_to_pl_v)
         stop_on_mismatch("PS-to-PL FIFO still valid after the model drained");
   endtask

   task automatic test_pl_to_ps();
      int n;
      for (int r = 0; r < RX_ROUNDS; r++)
      begin
         n = $urandom % 6;
         for (int k = 0; k < n; k++)
            push_pl_word($urandom);
         axil_read(ctrl_addr(REG_FLAGS, 2'd0));
         // often more reads than words, so empty reads happen too
         n = $urandom % 7;
         for (int k = 0; k < n; k++)
            axil_read(ctrl_addr(REG_RX_POP, 2'd0));
      end
   endtask

   task automatic test_host_xlate();
      check_host_pair(30'h2000_0000, 30'h2000_0001);
      check_host_pair(30'h0FFF_FFFF, HOST_ADDR_W'($urandom));
      for (int i = 0; i < HOST_ITERS; i++)
         check_host_pair(HOST_ADDR_W'($urandom), HOST_ADDR_W'($urandom));
   endtask

   task automatic test_dram_remap();
      axil_w_s w;
      for (int b = 0; b < DRAM_BASES; b++)
      begin
         w.data = $urandom;
         w.strb = '1;
         axil_write(ctrl_addr(REG_CSR2, 2'd0), w);
         check_dram_pair(MEM_ADDR_W'(BP_DRAM_BASE), MEM_ADDR_W'({$urandom, $urandom}));
         for (int i = 0; i < DRAM_ITERS; i++)
            check_dram_pair(MEM_ADDR_W'({$urandom, $urandom}), MEM_ADDR_W'({$urandom, $urandom}));
      end
   endtask

   initial
   begin : run_tests
      void'($urandom(32'hc0b6));
      csr_m = '0;
      arst_n        <= 1'b0;
      ctrl_aw       <= '0;
      ctrl_awvalid  <= 1'b0;
      ctrl_w        <= '0;
      ctrl_wvalid   <= 1'b0;
      ctrl_bready   <= 1'b1;
      ctrl_ar       <= '0;
      ctrl_arvalid  <= 1'b0;
      ctrl_rready   <= 1'b1;
      status        <= '0;
      pl_to_ps_data <= '0;
      pl_to_ps_v    <= 1'b0;
      host_awaddr   <= '0;
      host_araddr   <= '0;
      mem_awaddr    <= '0;
      mem_araddr    <= '0;
      pop_enable    <= 1'b0;
      repeat (16)
         @(posedge aclk);
      arst_n <= 1'b1;
      @(posedge aclk);
      // out of reset both FIFOs are empty and the bank is clear
      if (ps_to_pl_v || !pl_to_ps_ready)
         stop_on_mismatch("FIFO flags wrong after reset");
      if (ctrl_awready || ctrl_wready || ctrl_arready || ctrl_bvalid || ctrl_rvalid)
         stop_on_mismatch("AXI-lite ready or valid outputs high after reset");
      check_csr(csr, csr_m);
      axil_read(ctrl_addr(REG_FLAGS, 2'd0));
      test_csr();
      test_status();
      test_ps_to_pl();
      test_pl_to_ps();
      test_host_xlate();
      test_dram_remap();
      $display("RESULT: PASS");
      $finish;
   end

endmodule
